// ==== hw/fsa_pkg.sv ====
package fsa_pkg;

	// image geometry
	localparam int IMG_W = 32;
	localparam int IMG_H = 16;
	localparam int X_W   = 5;
	localparam int Y_W   = 4;
	localparam int PIX_W = 8;

	// fiber thickness check
	localparam int HEIGHT_TOL  = 2;
	localparam int HEADER_HALF = 3;
	localparam int HEADER_LEN  = 2 * HEADER_HALF + 1;

	typedef logic [PIX_W-1:0] pixel_t;
	typedef logic [X_W-1:0]   col_x_t;
	typedef logic [Y_W-1:0]   row_y_t;

	// one entry per column of the table
	typedef struct packed {
		logic   occupied;
		row_y_t top;
		row_y_t bot;
	} col_extent_t;

	typedef struct packed {
		logic   rd_en;
		logic   pass_height;
		logic   pass_header;
		logic   pass_corner;
		logic   first;
		logic   last;
		col_x_t x;
	} scan_ctl_t;

	typedef struct packed {
		logic   edge_valid;
		col_x_t edge_x;
		logic   header_valid;
		col_x_t header_x;
		logic   corner_valid;
		col_x_t top_x;
		row_y_t top_y;
		col_x_t bot_x;
		row_y_t bot_y;
	} fiber_result_t;

	typedef enum logic [2:0] {
		st_idle,
		st_height,
		st_header,
		st_corner,
		st_finish
	} scan_state_t;

endpackage

// ==== hw/fsa_column_ram.sv ====
`timescale 1ns/10ps

module fsa_column_ram (
	input  logic                 clk,
	input  logic                 wr_en,
	input  fsa_pkg::col_x_t      wr_x,
	input  fsa_pkg::col_extent_t wr_data,
	input  fsa_pkg::col_x_t      rd_a_x,
	output fsa_pkg::col_extent_t rd_a_data,
	input  fsa_pkg::col_x_t      rd_b_x,
	output fsa_pkg::col_extent_t rd_b_data
);

	fsa_pkg::col_extent_t mem [fsa_pkg::IMG_W];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_x] <= wr_data;
		end
	end

	// both read ports registered, old data on collision
	always_ff @(posedge clk) begin
		rd_a_data <= mem[rd_a_x];
		rd_b_data <= mem[rd_b_x];
	end

endmodule

// ==== hw/fsa_column_extent.sv ====
`timescale 1ns/10ps

module fsa_column_extent (
	input  logic                 clk,
	input  logic                 resetn,
	input  fsa_pkg::pixel_t      threshold,
	input  logic                 pix_valid,
	input  logic                 sof,
	input  fsa_pkg::pixel_t      pix,
	output logic                 wr_en,
	output fsa_pkg::col_x_t      wr_x,
	output fsa_pkg::col_extent_t wr_data,
	output fsa_pkg::col_x_t      rd_a_x,
	input  fsa_pkg::col_extent_t rd_a_data,
	output logic                 frame_done
);

	fsa_pkg::col_x_t x_cnt;
	fsa_pkg::row_y_t y_cnt;
	fsa_pkg::col_x_t cur_x;
	fsa_pkg::row_y_t cur_y;
	logic            last_col;
	logic            last_pix;

	logic            valid_d;
	logic            last_d;
	logic            bright_d;
	fsa_pkg::col_x_t x_d;
	fsa_pkg::row_y_t y_d;

	// sof forces the raster position back to the origin
	assign cur_x    = sof ? '0 : x_cnt;
	assign cur_y    = sof ? '0 : y_cnt;
	assign last_col = (cur_x == fsa_pkg::col_x_t'(fsa_pkg::IMG_W - 1));
	assign last_pix = last_col && (cur_y == fsa_pkg::row_y_t'(fsa_pkg::IMG_H - 1));

	assign rd_a_x = cur_x;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (pix_valid) begin
			if (last_col) begin
				x_cnt <= '0;
				y_cnt <= last_pix ? '0 : cur_y + 1'b1;
			end else begin
				x_cnt <= cur_x + 1'b1;
				y_cnt <= cur_y;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid_d    <= 1'b0;
			last_d     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			valid_d    <= pix_valid;
			last_d     <= pix_valid && last_pix;
			frame_done <= last_d;
		end
	end

	always_ff @(posedge clk) begin
		bright_d <= (pix >= threshold);
		x_d      <= cur_x;
		y_d      <= cur_y;
	end

	// read-modify-write, old entry arrives with the delayed pixel
	always_comb begin
		wr_data = rd_a_data;
		if (y_d == '0) begin
			wr_data = '0;
		end
		if (bright_d) begin
			if (!wr_data.occupied) begin
				wr_data.top = y_d;
			end
			wr_data.occupied = 1'b1;
			wr_data.bot      = y_d;
		end
	end

	assign wr_en = valid_d;
	assign wr_x  = x_d;

endmodule

// ==== hw/fsa_scan_sequencer.sv ====
`timescale 1ns/10ps

module fsa_scan_sequencer (
	input  logic               clk,
	input  logic               resetn,
	input  logic               frame_done,
	output fsa_pkg::col_x_t    rd_b_x,
	output fsa_pkg::scan_ctl_t scan,
	output logic               scan_done
);

	fsa_pkg::scan_state_t state;
	fsa_pkg::col_x_t      x_q;
	logic                 gap_q;
	logic                 in_pass;
	fsa_pkg::scan_ctl_t   scan_nxt;

	function automatic fsa_pkg::scan_state_t next_pass(input fsa_pkg::scan_state_t s);
		case (s)
			fsa_pkg::st_height: return fsa_pkg::st_header;
			fsa_pkg::st_header: return fsa_pkg::st_corner;
			default:            return fsa_pkg::st_finish;
		endcase
	endfunction

	assign in_pass = (state == fsa_pkg::st_height) ||
	                 (state == fsa_pkg::st_header) ||
	                 (state == fsa_pkg::st_corner);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= fsa_pkg::st_idle;
			x_q   <= '0;
			gap_q <= 1'b0;
		end else begin
			case (state)
				fsa_pkg::st_idle: begin
					x_q   <= '0;
					gap_q <= 1'b0;
					if (frame_done) begin
						state <= fsa_pkg::st_height;
					end
				end
				fsa_pkg::st_finish: begin
					state <= fsa_pkg::st_idle;
				end
				default: begin
					// one dead cycle closes every pass
					if (gap_q) begin
						gap_q <= 1'b0;
						state <= next_pass(state);
					end else if (x_q == fsa_pkg::col_x_t'(fsa_pkg::IMG_W - 1)) begin
						x_q   <= '0;
						gap_q <= 1'b1;
					end else begin
						x_q <= x_q + 1'b1;
					end
				end
			endcase
		end
	end

	always_comb begin
		scan_nxt             = '0;
		scan_nxt.rd_en       = in_pass && !gap_q;
		scan_nxt.pass_height = (state == fsa_pkg::st_height);
		scan_nxt.pass_header = (state == fsa_pkg::st_header);
		scan_nxt.pass_corner = (state == fsa_pkg::st_corner);
		scan_nxt.first       = scan_nxt.rd_en && (x_q == '0);
		scan_nxt.last        = scan_nxt.rd_en && (x_q == fsa_pkg::col_x_t'(fsa_pkg::IMG_W - 1));
		scan_nxt.x           = x_q;
	end

	// aligned with the table's registered read
	always_ff @(posedge clk) begin
		if (!resetn) begin
			scan <= '0;
		end else begin
			scan <= scan_nxt;
		end
	end

	assign rd_b_x    = x_q;
	assign scan_done = (state == fsa_pkg::st_finish);

endmodule

// ==== hw/fsa_detect_edge.sv ====
`timescale 1ns/10ps

module fsa_detect_edge (
	input  logic                   clk,
	input  logic                   resetn,
	input  fsa_pkg::scan_ctl_t     scan,
	input  fsa_pkg::col_extent_t   col,
	input  logic                   scan_done,
	output logic                   ana_done,
	output fsa_pkg::fiber_result_t res_lft,
	output fsa_pkg::fiber_result_t res_rt
);

	localparam int WIN = fsa_pkg::HEADER_LEN;

	// one extra bit of headroom for the tolerance bounds
	typedef logic [fsa_pkg::Y_W:0] tol_h_t;

	fsa_pkg::scan_ctl_t     sc;
	fsa_pkg::col_extent_t   cl;
	logic                   done_q;

	logic                   lft_occ0;
	logic                   rt_occ31;
	tol_h_t                 lft_lo;
	tol_h_t                 lft_hi;
	tol_h_t                 rt_lo;
	tol_h_t                 rt_hi;

	fsa_pkg::row_y_t        hgt;
	tol_h_t                 hgt_ext;
	logic                   lft_run;
	logic                   lft_run_now;
	logic                   rt_prev_occ;
	logic                   rt_start;
	logic                   lft_flag;
	logic                   rt_flag;
	logic [WIN-1:0]         lft_win;
	logic [WIN-1:0]         rt_win;
	logic [WIN-1:0]         lft_win_nxt;
	logic [WIN-1:0]         rt_win_nxt;
	fsa_pkg::col_x_t        hdr_cand;

	logic                   lft_hdr_found;
	logic                   rt_hdr_found;
	fsa_pkg::col_x_t        lft_hdr_x;
	fsa_pkg::col_x_t        rt_hdr_x;

	fsa_pkg::col_x_t        lft_edge;
	fsa_pkg::col_x_t        lft_top_x;
	fsa_pkg::col_x_t        lft_bot_x;
	fsa_pkg::row_y_t        lft_top_y;
	fsa_pkg::row_y_t        lft_bot_y;
	fsa_pkg::col_x_t        rt_edge;
	fsa_pkg::col_x_t        rt_top_x;
	fsa_pkg::col_x_t        rt_bot_x;
	fsa_pkg::row_y_t        rt_top_y;
	fsa_pkg::row_y_t        rt_bot_y;

	fsa_pkg::fiber_result_t lft_res;
	fsa_pkg::fiber_result_t rt_res;

	function automatic tol_h_t tol_low(input fsa_pkg::row_y_t h);
		tol_h_t hx;
		hx = tol_h_t'(h);
		return (hx > tol_h_t'(fsa_pkg::HEIGHT_TOL)) ? hx - tol_h_t'(fsa_pkg::HEIGHT_TOL) : '0;
	endfunction

	function automatic tol_h_t tol_high(input fsa_pkg::row_y_t h);
		return tol_h_t'(h) + tol_h_t'(fsa_pkg::HEIGHT_TOL);
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sc       <= '0;
			done_q   <= 1'b0;
			ana_done <= 1'b0;
		end else begin
			sc       <= scan;
			done_q   <= scan_done;
			ana_done <= done_q;
		end
	end

	always_ff @(posedge clk) begin
		cl <= col;
	end

	assign hgt         = cl.bot - cl.top;
	assign hgt_ext     = tol_h_t'(hgt);
	assign lft_run_now = cl.occupied && (sc.first || lft_run);
	assign rt_start    = cl.occupied && (sc.first || !rt_prev_occ);
	assign lft_flag    = lft_run_now && (hgt_ext >= lft_lo) && (hgt_ext <= lft_hi);
	assign rt_flag     = cl.occupied && (hgt_ext >= rt_lo) && (hgt_ext <= rt_hi);
	assign lft_win_nxt = sc.first ? {{(WIN-1){1'b0}}, lft_flag} : {lft_win[WIN-2:0], lft_flag};
	assign rt_win_nxt  = sc.first ? {{(WIN-1){1'b0}}, rt_flag} : {rt_win[WIN-2:0], rt_flag};
	assign hdr_cand    = sc.x - fsa_pkg::col_x_t'(fsa_pkg::HEADER_HALF);

	// height pass, border columns
	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_occ0 <= 1'b0;
			rt_occ31 <= 1'b0;
		end else if (sc.rd_en && sc.pass_height) begin
			if (sc.first) begin
				lft_occ0 <= cl.occupied;
			end
			if (sc.last) begin
				rt_occ31 <= cl.occupied;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sc.rd_en && sc.pass_height) begin
			if (sc.first) begin
				lft_lo <= tol_low(hgt);
				lft_hi <= tol_high(hgt);
			end
			if (sc.last) begin
				rt_lo <= tol_low(hgt);
				rt_hi <= tol_high(hgt);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sc.rd_en) begin
			lft_run     <= lft_run_now;
			rt_prev_occ <= cl.occupied;
		end
	end

	// header pass: left keeps the last full window, right the first of its run
	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_hdr_found <= 1'b0;
			rt_hdr_found  <= 1'b0;
		end else if (sc.rd_en && sc.pass_header) begin
			if (sc.first) begin
				lft_hdr_found <= 1'b0;
			end else if (&lft_win_nxt) begin
				lft_hdr_found <= 1'b1;
			end
			if (sc.first || !cl.occupied) begin
				rt_hdr_found <= 1'b0;
			end else if (&rt_win_nxt) begin
				rt_hdr_found <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sc.rd_en && sc.pass_header) begin
			lft_win <= lft_win_nxt;
			rt_win  <= rt_win_nxt;
			if (&lft_win_nxt) begin
				lft_hdr_x <= hdr_cand;
			end
			if (&rt_win_nxt && !rt_hdr_found) begin
				rt_hdr_x <= hdr_cand;
			end
		end
	end

	// corner pass, left: header_x up to the edge, ties to larger x
	always_ff @(posedge clk) begin
		if (sc.rd_en && sc.pass_corner && lft_run_now) begin
			lft_edge <= sc.x;
			if (sc.x == lft_hdr_x) begin
				lft_top_x <= sc.x;
				lft_top_y <= cl.top;
				lft_bot_x <= sc.x;
				lft_bot_y <= cl.bot;
			end else if (sc.x > lft_hdr_x) begin
				if (cl.top <= lft_top_y) begin
					lft_top_x <= sc.x;
					lft_top_y <= cl.top;
				end
				if (cl.bot >= lft_bot_y) begin
					lft_bot_x <= sc.x;
					lft_bot_y <= cl.bot;
				end
			end
		end
	end

	// right restarts at every run start; the last run is the right fiber
	always_ff @(posedge clk) begin
		if (sc.rd_en && sc.pass_corner) begin
			if (rt_start) begin
				rt_edge  <= sc.x;
				rt_top_x <= sc.x;
				rt_top_y <= cl.top;
				rt_bot_x <= sc.x;
				rt_bot_y <= cl.bot;
			end else if (cl.occupied && sc.x <= rt_hdr_x) begin
				if (cl.top < rt_top_y) begin
					rt_top_x <= sc.x;
					rt_top_y <= cl.top;
				end
				if (cl.bot > rt_bot_y) begin
					rt_bot_x <= sc.x;
					rt_bot_y <= cl.bot;
				end
			end
		end
	end

	always_comb begin
		lft_res            = '0;
		lft_res.edge_valid = lft_occ0;
		if (lft_occ0) begin
			lft_res.edge_x = lft_edge;
		end
		if (lft_hdr_found) begin
			lft_res.header_valid = 1'b1;
			lft_res.header_x     = lft_hdr_x;
			lft_res.corner_valid = 1'b1;
			lft_res.top_x        = lft_top_x;
			lft_res.top_y        = lft_top_y;
			lft_res.bot_x        = lft_bot_x;
			lft_res.bot_y        = lft_bot_y;
		end
	end

	always_comb begin
		rt_res            = '0;
		rt_res.edge_valid = rt_occ31;
		if (rt_occ31) begin
			rt_res.edge_x = rt_edge;
		end
		if (rt_hdr_found) begin
			rt_res.header_valid = 1'b1;
			rt_res.header_x     = rt_hdr_x;
			rt_res.corner_valid = 1'b1;
			rt_res.top_x        = rt_top_x;
			rt_res.top_y        = rt_top_y;
			rt_res.bot_x        = rt_bot_x;
			rt_res.bot_y        = rt_bot_y;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			res_lft <= '0;
			res_rt  <= '0;
		end else if (done_q) begin
			res_lft <= lft_res;
			res_rt  <= rt_res;
		end
	end

endmodule

// ==== hw/fsa_analyzer_top.sv ====
`timescale 1ns/10ps

module fsa_analyzer_top (
	input  logic                   clk,
	input  logic                   resetn,
	input  fsa_pkg::pixel_t        threshold,
	input  logic                   pix_valid,
	input  logic                   sof,
	input  fsa_pkg::pixel_t        pix,
	output logic                   ana_done,
	output fsa_pkg::fiber_result_t res_lft,
	output fsa_pkg::fiber_result_t res_rt
);

	logic                 wr_en;
	fsa_pkg::col_x_t      wr_x;
	fsa_pkg::col_extent_t wr_data;
	fsa_pkg::col_x_t      rd_a_x;
	fsa_pkg::col_extent_t rd_a_data;
	fsa_pkg::col_x_t      rd_b_x;
	fsa_pkg::col_extent_t rd_b_data;
	logic                 frame_done;
	fsa_pkg::scan_ctl_t   scan;
	logic                 scan_done;

	fsa_column_extent u_extent (
		.clk        (clk),
		.resetn     (resetn),
		.threshold  (threshold),
		.pix_valid  (pix_valid),
		.sof        (sof),
		.pix        (pix),
		.wr_en      (wr_en),
		.wr_x       (wr_x),
		.wr_data    (wr_data),
		.rd_a_x     (rd_a_x),
		.rd_a_data  (rd_a_data),
		.frame_done (frame_done)
	);

	fsa_column_ram u_ram (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_x      (wr_x),
		.wr_data   (wr_data),
		.rd_a_x    (rd_a_x),
		.rd_a_data (rd_a_data),
		.rd_b_x    (rd_b_x),
		.rd_b_data (rd_b_data)
	);

	fsa_scan_sequencer u_seq (
		.clk        (clk),
		.resetn     (resetn),
		.frame_done (frame_done),
		.rd_b_x     (rd_b_x),
		.scan       (scan),
		.scan_done  (scan_done)
	);

	fsa_detect_edge u_detect (
		.clk       (clk),
		.resetn    (resetn),
		.scan      (scan),
		.col       (rd_b_data),
		.scan_done (scan_done),
		.ana_done  (ana_done),
		.res_lft   (res_lft),
		.res_rt    (res_rt)
	);

endmodule

// ==== testbench/fsa_analyzer_tb.sv ====
`timescale 1ns/10ps

module fsa_analyzer_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int NUM_FRAMES   = 6;
	localparam int NONE         = -1;
	localparam int BRIGHT       = 200;
	localparam int FRAME_CYCLES = fsa_pkg::IMG_W * fsa_pkg::IMG_H * 2 + 4 * fsa_pkg::IMG_W;

	// left fiber, left end taper, right fiber, expected results
	typedef struct packed {
		int                     lft_last;
		int                     lft_top;
		int                     lft_bot;
		int                     taper_n;
		int                     taper_d;
		int                     rt_first;
		int                     rt_top;
		int                     rt_bot;
		fsa_pkg::fiber_result_t exp_lft;
		fsa_pkg::fiber_result_t exp_rt;
	} frame_t;

	logic                   clk;
	logic                   resetn;
	fsa_pkg::pixel_t        threshold;
	logic                   pix_valid;
	logic                   sof;
	fsa_pkg::pixel_t        pix;
	logic                   ana_done;
	fsa_pkg::fiber_result_t res_lft;
	fsa_pkg::fiber_result_t res_rt;

	integer                 seed;
	int                     done_count = 0;
	frame_t                 frames [NUM_FRAMES];

	fsa_analyzer_top dut (
		.clk       (clk),
		.resetn    (resetn),
		.threshold (threshold),
		.pix_valid (pix_valid),
		.sof       (sof),
		.pix       (pix),
		.ana_done  (ana_done),
		.res_lft   (res_lft),
		.res_rt    (res_rt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(negedge clk) begin
		if (ana_done) begin
			done_count = done_count + 1;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_col_x(input string name, input fsa_pkg::col_x_t got,
			input fsa_pkg::col_x_t exp);
		if (got !== exp) begin
			abort_run($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_row_y(input string name, input fsa_pkg::row_y_t got,
			input fsa_pkg::row_y_t exp);
		if (got !== exp) begin
			abort_run($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_result(input string side, input fsa_pkg::fiber_result_t got,
			input fsa_pkg::fiber_result_t exp);
		check_flag({side, ".edge_valid"}, got.edge_valid, exp.edge_valid);
		check_col_x({side, ".edge_x"}, got.edge_x, exp.edge_x);
		check_flag({side, ".header_valid"}, got.header_valid, exp.header_valid);
		check_col_x({side, ".header_x"}, got.header_x, exp.header_x);
		check_flag({side, ".corner_valid"}, got.corner_valid, exp.corner_valid);
		check_col_x({side, ".top_x"}, got.top_x, exp.top_x);
		check_row_y({side, ".top_y"}, got.top_y, exp.top_y);
		check_col_x({side, ".bot_x"}, got.bot_x, exp.bot_x);
		check_row_y({side, ".bot_y"}, got.bot_y, exp.bot_y);
	endtask

	// corner_valid follows header_valid
	function automatic fsa_pkg::fiber_result_t make_result(input int ev, input int e,
			input int hv, input int hx, input int tx, input int ty, input int bx, input int by);
		fsa_pkg::fiber_result_t r;
		r.edge_valid   = (ev != 0);
		r.edge_x       = fsa_pkg::col_x_t'(e);
		r.header_valid = (hv != 0);
		r.header_x     = fsa_pkg::col_x_t'(hx);
		r.corner_valid = (hv != 0);
		r.top_x        = fsa_pkg::col_x_t'(tx);
		r.top_y        = fsa_pkg::row_y_t'(ty);
		r.bot_x        = fsa_pkg::col_x_t'(bx);
		r.bot_y        = fsa_pkg::row_y_t'(by);
		return r;
	endfunction

	// tapered end columns start lower
	function automatic bit is_bright(input frame_t f, input int x, input int y);
		int top;
		top = f.lft_top;
		if (x > f.lft_last - f.taper_n) begin
			top = f.lft_top + f.taper_d;
		end
		if (f.lft_last != NONE && x <= f.lft_last && y >= top && y <= f.lft_bot) begin
			return 1'b1;
		end
		return f.rt_first != NONE && x >= f.rt_first && y >= f.rt_top && y <= f.rt_bot;
	endfunction

	task automatic fill_table();
		frames[0] = '{11, 4, 10, 0, 0, 20, 5, 11,
			make_result(1, 11, 1, 8, 11, 4, 11, 10), make_result(1, 20, 1, 23, 20, 5, 20, 11)};
		// column 0 dark
		frames[1] = '{NONE, 0, 0, 0, 0, 14, 2, 12,
			make_result(0, 0, 0, 0, 0, 0, 0, 0), make_result(1, 14, 1, 17, 14, 2, 14, 12)};
		// left fiber too short for a header
		frames[2] = '{4, 6, 9, 0, 0, 24, 3, 8,
			make_result(1, 4, 0, 0, 0, 0, 0, 0), make_result(1, 24, 1, 27, 24, 3, 24, 8)};
		// last 2 left columns shortened by 3 rows
		frames[3] = '{13, 3, 11, 2, 3, 22, 4, 9,
			make_result(1, 13, 1, 8, 11, 3, 13, 11), make_result(1, 22, 1, 25, 22, 4, 22, 9)};
		frames[4] = '{20, 0, 15, 0, 0, 26, 7, 8,
			make_result(1, 20, 1, 17, 20, 0, 20, 15), make_result(1, 26, 0, 0, 0, 0, 0, 0)};
		frames[5] = '{15, 8, 12, 0, 0, NONE, 0, 0,
			make_result(1, 15, 1, 12, 15, 8, 15, 12), make_result(0, 0, 0, 0, 0, 0, 0, 0)};
	endtask

	task automatic drive_frame(input frame_t f);
		fsa_pkg::pixel_t value;
		for (int y = 0; y < fsa_pkg::IMG_H; y++) begin
			for (int x = 0; x < fsa_pkg::IMG_W; x++) begin
				if (is_bright(f, x, y)) begin
					value = fsa_pkg::pixel_t'(BRIGHT);
				end else begin
					value = fsa_pkg::pixel_t'($random(seed) & 127);
				end
				if (($random(seed) & 1) == 1) begin
					@(posedge clk);
					pix_valid <= 1'b0;
					sof       <= 1'b0;
				end
				@(posedge clk);
				pix_valid <= 1'b1;
				sof       <= (x == 0 && y == 0);
				pix       <= value;
			end
		end
		@(posedge clk);
		pix_valid <= 1'b0;
		sof       <= 1'b0;
	endtask

	task automatic wait_analysis();
		@(negedge clk);
		while (!ana_done) begin
			@(negedge clk);
		end
	endtask

	initial begin
		#((NUM_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before all frames were analyzed");
	end

	initial begin
		seed      = 32'h3729;
		clk       = 1'b0;
		resetn    = 1'b0;
		threshold = fsa_pkg::pixel_t'(128);
		pix_valid = 1'b0;
		sof       = 1'b0;
		pix       = '0;
		fill_table();
		repeat (3) @(posedge clk);
		resetn <= 1'b1;

		// nothing happens before the first frame
		repeat (20) begin
			@(negedge clk);
			check_flag("ana_done", ana_done, 1'b0);
		end
		check_result("idle res_lft", res_lft, '0);
		check_result("idle res_rt", res_rt, '0);

		for (int i = 0; i < NUM_FRAMES; i++) begin
			drive_frame(frames[i]);
			wait_analysis();
			check_result($sformatf("frame %0d res_lft", i), res_lft, frames[i].exp_lft);
			check_result($sformatf("frame %0d res_rt", i), res_rt, frames[i].exp_rt);
			@(negedge clk);
			check_flag("ana_done", ana_done, 1'b0);
			if (done_count != i + 1) begin
				abort_run("ana_done pulsed a different number of times than frames were sent");
			end
			// inter-frame gap
			repeat (4 * fsa_pkg::IMG_W) @(posedge clk);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== fsa_analyzer.f ====
hw/fsa_pkg.sv
hw/fsa_column_ram.sv
hw/fsa_column_extent.sv
hw/fsa_scan_sequencer.sv
hw/fsa_detect_edge.sv
hw/fsa_analyzer_top.sv
testbench/fsa_analyzer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fiber splice analyzer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --top-module fsa_analyzer_tb -Mdir obj_dir -f fsa_analyzer.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vfsa_analyzer_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
